//--- src/ppu_pkg.sv
// Shared widths, raster constants and register addresses for the PPU bus core
// Imported by every module of the design
`default_nettype none

package ppu_pkg;

    // CPU and program bus address
    typedef logic [15:0] cpu_addr_t;
    typedef logic [7:0]  byte_t;
    // Raw VGA counter and picture processor dot counter
    typedef logic [9:0]  vga_pos_t;
    typedef logic [8:0]  dot_pos_t;

    // Three dot ticks make one CPU cycle
    typedef enum logic [1:0] {
        PHASE_IDLE     = 2'd0,
        PHASE_REQUEST  = 2'd1,
        PHASE_RESPONSE = 2'd2
    } cpu_phase_t;

    // ------------------------------------------------------------------
    // VGA 800 x 525 raster
    // ------------------------------------------------------------------
    localparam int H_VISIBLE = 640;
    localparam int H_FRONT   = 16;
    localparam int H_SYNC    = 96;
    localparam int H_BACK    = 48;
    localparam int H_TOTAL   = 800;
    localparam int V_VISIBLE = 480;
    localparam int V_FRONT   = 10;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 33;
    localparam int V_TOTAL   = 525;

    // Picture processor line and blanking events
    localparam int DOTS_PER_LINE     = 341;
    localparam int VBLANK_SET_LINE   = 257;
    localparam int VBLANK_CLEAR_LINE = 16;
    localparam int BLANK_EVENT_DOT   = 1;

    // I/O ports outside the $2000 window
    localparam cpu_addr_t REG_DMA = 16'h4014;
    localparam cpu_addr_t REG_JOY = 16'h4016;

    // Control register values after reset
    localparam byte_t CTRL0_RESET = 8'h10;
    localparam byte_t CTRL1_RESET = 8'h0E;

endpackage

`default_nettype wire

//--- src/raster_timing.sv
// VGA raster counters and the 341-dot picture processor window inside them
// Produces sync levels, the dot tick and the two vertical blank events
`default_nettype none

module raster_timing
    import ppu_pkg::*;
(
    input  logic     clock25,
    input  logic     reset_n,
    output logic     hs_o,
    output logic     vs_o,
    output dot_pos_t px_o,
    output dot_pos_t py_o,
    output logic     dot_tick_o,
    output logic     vblank_set_o,
    output logic     vblank_clear_o
);

    vga_pos_t x;
    vga_pos_t y;
    logic     x_last;
    logic     y_last;
    logic     in_window;
    logic     tick;
    logic     event_dot;

    assign x_last    = (x == vga_pos_t'(H_TOTAL - 1));
    assign y_last    = (y == vga_pos_t'(V_TOTAL - 1));
    assign in_window = (int'(x) >= H_BACK) && (int'(x) < H_BACK + 2 * DOTS_PER_LINE);
    // One dot covers 2x2 VGA pixels, odd column of an odd line
    assign tick      = in_window && x[0] && y[0];
    assign event_dot = tick && (px_o == dot_pos_t'(BLANK_EVENT_DOT));

    // Both syncs are negative
    assign hs_o = (int'(x) < H_VISIBLE + H_FRONT + H_SYNC);
    assign vs_o = !((int'(y) >= V_BACK + V_VISIBLE + V_FRONT) &&
                    (int'(y) <  V_BACK + V_VISIBLE + V_FRONT + V_SYNC));

    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            x              <= '0;
            y              <= '0;
            px_o           <= '0;
            py_o           <= '0;
            dot_tick_o     <= 1'b0;
            vblank_set_o   <= 1'b0;
            vblank_clear_o <= 1'b0;
        end else begin
            x <= x_last ? '0 : x + 1'b1;
            if (x_last) begin
                y <= y_last ? '0 : y + 1'b1;
            end

            dot_tick_o     <= tick;
            vblank_set_o   <= event_dot && (py_o == dot_pos_t'(VBLANK_SET_LINE));
            vblank_clear_o <= event_dot && (py_o == dot_pos_t'(VBLANK_CLEAR_LINE));

            // Whole last VGA line holds the dot counters at the frame origin
            if (y_last) begin
                px_o <= '0;
                py_o <= '0;
            end else if (x_last) begin
                px_o <= '0;
            end else if (tick) begin
                if (px_o == dot_pos_t'(DOTS_PER_LINE - 1)) begin
                    px_o <= '0;
                    py_o <= py_o + 1'b1;
                end else begin
                    px_o <= px_o + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/prg_bus_arbiter.sv
// CPU slot sequencer and owner of the shared program bus and OAM port
// Each slot of three dot ticks goes either to the register file or to OAM DMA
`default_nettype none

module prg_bus_arbiter
    import ppu_pkg::*;
(
    input  logic      clock25,
    input  logic      reset_n,
    input  logic      dot_tick_i,
    input  logic      dma_active_i,
    input  cpu_addr_t cpu_prga_i,
    input  byte_t     cpu_prgd_i,
    input  logic      cpu_prgw_i,
    input  byte_t     cpu_oama_i,
    input  byte_t     cpu_oamd_i,
    input  logic      cpu_oamw_i,
    input  cpu_addr_t dma_prga_i,
    input  byte_t     dma_oamd_i,
    input  byte_t     dma_oama_i,
    input  logic      dma_oamw_i,
    output logic      ce_cpu_o,
    output logic      ce_ppu_o,
    output logic      cpu_req_o,
    output logic      cpu_resp_o,
    output logic      dma_read_o,
    output logic      dma_advance_o,
    output cpu_addr_t prga_o,
    output byte_t     prgd_o,
    output logic      prgw_o,
    output byte_t     oama_o,
    output byte_t     oamd_o,
    output logic      oamw_o
);

    cpu_phase_t phase;
    cpu_phase_t phase_next;
    logic       tick_req;
    logic       tick_resp;

    always_comb begin
        case (phase)
            PHASE_IDLE:    phase_next = PHASE_REQUEST;
            PHASE_REQUEST: phase_next = PHASE_RESPONSE;
            default:       phase_next = PHASE_IDLE;
        endcase
    end

    assign tick_req  = dot_tick_i && (phase == PHASE_REQUEST);
    assign tick_resp = dot_tick_i && (phase == PHASE_RESPONSE);

    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            phase         <= PHASE_IDLE;
            ce_cpu_o      <= 1'b0;
            ce_ppu_o      <= 1'b0;
            cpu_req_o     <= 1'b0;
            cpu_resp_o    <= 1'b0;
            dma_read_o    <= 1'b0;
            dma_advance_o <= 1'b0;
            prgw_o        <= 1'b0;
            oamw_o        <= 1'b0;
        end else begin
            if (dot_tick_i) begin
                phase <= phase_next;
            end
            ce_ppu_o      <= dot_tick_i;
            // CPU is stalled for the whole DMA copy
            ce_cpu_o      <= dot_tick_i && (phase == PHASE_IDLE) && !dma_active_i;
            cpu_req_o     <= tick_req && !dma_active_i;
            cpu_resp_o    <= tick_resp && !dma_active_i;
            dma_read_o    <= tick_req && dma_active_i;
            dma_advance_o <= tick_resp && dma_active_i;
            prgw_o        <= cpu_prgw_i && !dma_active_i;
            oamw_o        <= dma_active_i ? dma_oamw_i : cpu_oamw_i;
        end
    end

    // Address and data follow the slot owner
    always_ff @(posedge clock25) begin
        prgd_o <= cpu_prgd_i;
        if (dma_active_i) begin
            prga_o <= dma_prga_i;
            oama_o <= dma_oama_i;
            oamd_o <= dma_oamd_i;
        end else begin
            prga_o <= cpu_prga_i;
            oama_o <= cpu_oama_i;
            oamd_o <= cpu_oamd_i;
        end
    end

endmodule

`default_nettype wire

//--- src/ppu_registers.sv
// CPU-visible register file of the picture processor
// Decodes the CPU access once and serves registers, OAM, DMA, joypad and program memory
`default_nettype none

module ppu_registers
    import ppu_pkg::*;
(
    input  logic      clock25,
    input  logic      reset_n,
    input  logic      cpu_req_i,
    input  logic      cpu_resp_i,
    input  cpu_addr_t cpu_a_i,
    input  byte_t     cpu_o_i,
    input  logic      cpu_w_i,
    input  logic      cpu_r_i,
    input  logic      vblank_set_i,
    input  logic      vblank_clear_i,
    input  byte_t     prgi_i,
    input  byte_t     oami_i,
    input  logic      joy_bit_i,
    output byte_t     cpu_i_o,
    output logic      nmi_o,
    output cpu_addr_t prga_o,
    output byte_t     prgd_o,
    output logic      prgw_o,
    output byte_t     oama_o,
    output byte_t     oamd_o,
    output logic      oamw_o,
    output logic      dma_start_o,
    output byte_t     dma_page_o,
    output logic      joy_write_o,
    output logic      joy_latch_bit_o,
    output logic      joy_shift_o
);

    logic       is_ppu;
    logic       is_dma;
    logic       is_joy;
    logic       is_prg;
    logic       is_oam_data;
    logic [2:0] reg_sel;
    byte_t      ctrl0;
    byte_t      ctrl1;
    byte_t      oam_addr;
    logic       vblank;
    logic       dma_armed;

    // ------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------
    assign is_ppu      = (cpu_a_i[15:13] == 3'b001);
    assign is_dma      = (cpu_a_i == REG_DMA);
    assign is_joy      = (cpu_a_i == REG_JOY);
    assign is_prg      = !(is_ppu || is_dma || is_joy);
    // Registers mirror every 8 bytes
    assign reg_sel     = cpu_a_i[2:0];
    assign is_oam_data = is_ppu && (reg_sel == 3'd4);

    // Requests toward the arbiter
    assign prga_o          = cpu_a_i;
    assign prgd_o          = cpu_o_i;
    assign prgw_o          = cpu_req_i && cpu_w_i && is_prg;
    assign oama_o          = oam_addr;
    assign oamd_o          = cpu_o_i;
    assign oamw_o          = cpu_req_i && cpu_w_i && is_oam_data;
    assign dma_start_o     = cpu_resp_i && dma_armed;
    assign joy_write_o     = cpu_req_i && cpu_w_i && is_joy;
    assign joy_latch_bit_o = cpu_o_i[0];
    assign joy_shift_o     = cpu_resp_i && cpu_r_i && is_joy;

    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            ctrl0     <= CTRL0_RESET;
            ctrl1     <= CTRL1_RESET;
            oam_addr  <= '0;
            vblank    <= 1'b0;
            nmi_o     <= 1'b0;
            dma_armed <= 1'b0;
        end else begin
            if (cpu_req_i && is_dma && cpu_w_i) begin
                dma_armed <= 1'b1;
                oam_addr  <= '0;
            end
            if (cpu_req_i && is_ppu) begin
                case (reg_sel)
                    3'd0: if (cpu_w_i) ctrl0 <= cpu_o_i;
                    3'd1: if (cpu_w_i) ctrl1 <= cpu_o_i;
                    3'd2: if (cpu_r_i) vblank <= 1'b0;
                    3'd3: if (cpu_w_i) oam_addr <= cpu_o_i;
                    default: ;
                endcase
            end
            if (cpu_resp_i) begin
                dma_armed <= 1'b0;
                if (is_oam_data && (cpu_w_i || cpu_r_i)) begin
                    oam_addr <= oam_addr + 1'b1;
                end
            end
            if (vblank_set_i) begin
                vblank <= 1'b1;
                nmi_o  <= ctrl0[7];
            end
            if (vblank_clear_i) begin
                vblank <= 1'b0;
                nmi_o  <= 1'b0;
            end
        end
    end

    // Read data and DMA page
    always_ff @(posedge clock25) begin
        if (cpu_req_i && is_dma && cpu_w_i) begin
            dma_page_o <= cpu_o_i;
        end
        // Status answers at request so the read can clear the flag
        if (cpu_req_i && cpu_r_i && is_ppu && (reg_sel == 3'd2)) begin
            cpu_i_o <= {vblank, 2'b00, 1'b1, 4'b0000};
        end
        if (cpu_resp_i && cpu_r_i) begin
            if (is_prg) begin
                cpu_i_o <= prgi_i;
            end else if (is_joy) begin
                cpu_i_o <= {7'b0100000, joy_bit_i};
            end else if (is_ppu) begin
                case (reg_sel)
                    3'd0: cpu_i_o <= ctrl0;
                    3'd1: cpu_i_o <= ctrl1;
                    3'd4: cpu_i_o <= oami_i;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- src/oam_dma.sv
// Sprite DMA, copies one 256-byte page of program memory into OAM
// Moves one byte per CPU slot while the arbiter holds the CPU
`default_nettype none

module oam_dma
    import ppu_pkg::*;
(
    input  logic      clock25,
    input  logic      reset_n,
    input  logic      dma_start_i,
    input  byte_t     dma_page_i,
    input  logic      dma_read_i,
    input  logic      dma_advance_i,
    input  byte_t     prgi_i,
    output logic      dma_active_o,
    output cpu_addr_t prga_o,
    output byte_t     oama_o,
    output byte_t     oamd_o,
    output logic      oamw_o
);

    byte_t page;
    byte_t index;

    // Source and destination share the low byte
    assign prga_o = {page, index};
    assign oama_o = index;
    assign oamd_o = prgi_i;
    assign oamw_o = dma_active_o && dma_read_i;

    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            dma_active_o <= 1'b0;
            index        <= '0;
        end else if (dma_start_i) begin
            dma_active_o <= 1'b1;
            index        <= '0;
        end else if (dma_active_o && dma_advance_i) begin
            index <= index + 1'b1;
            if (index == 8'hFF) begin
                dma_active_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock25) begin
        if (dma_start_i) begin
            page <= dma_page_i;
        end
    end

endmodule

`default_nettype wire

//--- src/joypad_port.sv
// Serial interface of the two controllers behind port $4016
// A 1 then 0 write latches the buttons, each read shifts one bit out
`default_nettype none

module joypad_port
    import ppu_pkg::*;
(
    input  logic  clock25,
    input  logic  reset_n,
    input  logic  joy_write_i,
    input  logic  joy_latch_bit_i,
    input  logic  joy_shift_i,
    input  byte_t joy1_i,
    input  byte_t joy2_i,
    output logic  joy_bit_o
);

    logic        strobe_q;
    logic [23:0] joy1_sr;
    logic [23:0] joy2_sr;

    assign joy_bit_o = joy1_sr[0];

    always_ff @(posedge clock25) begin
        if (!reset_n) begin
            strobe_q <= 1'b0;
            joy1_sr  <= '0;
            joy2_sr  <= '0;
        end else if (joy_write_i) begin
            strobe_q <= joy_latch_bit_i;
            // Falling strobe, buttons then the signature bit at 19
            if (strobe_q && !joy_latch_bit_i) begin
                joy1_sr <= {16'h0800, joy1_i};
                joy2_sr <= {16'h0800, joy2_i};
            end
        end else if (joy_shift_i) begin
            joy1_sr <= joy1_sr >> 1;
        end
    end

endmodule

`default_nettype wire

//--- src/ppu_core.sv
// Top of the picture processor bus and timing core
// Connects raster timing, slot arbiter, register file, sprite DMA and joypads
`default_nettype none

module ppu_core
    import ppu_pkg::*;
(
    input  logic      clock25,
    input  logic      reset_n,
    input  cpu_addr_t cpu_a_i,
    input  byte_t     cpu_o_i,
    input  logic      cpu_w_i,
    input  logic      cpu_r_i,
    input  byte_t     joy1_i,
    input  byte_t     joy2_i,
    input  byte_t     prgi_i,
    input  byte_t     oami_i,
    output logic      hs_o,
    output logic      vs_o,
    output dot_pos_t  px_o,
    output dot_pos_t  py_o,
    output byte_t     cpu_i_o,
    output cpu_addr_t prga_o,
    output byte_t     prgd_o,
    output logic      prgw_o,
    output byte_t     oama_o,
    output byte_t     oamd_o,
    output logic      oamw_o,
    output logic      ce_cpu_o,
    output logic      ce_ppu_o,
    output logic      nmi_o
);

    logic      dot_tick;
    logic      vblank_set;
    logic      vblank_clear;
    logic      cpu_req;
    logic      cpu_resp;
    logic      dma_read;
    logic      dma_advance;
    logic      dma_active;
    logic      dma_start;
    byte_t     dma_page;
    cpu_addr_t reg_prga;
    byte_t     reg_prgd;
    logic      reg_prgw;
    byte_t     reg_oama;
    byte_t     reg_oamd;
    logic      reg_oamw;
    cpu_addr_t dma_prga;
    byte_t     dma_oama;
    byte_t     dma_oamd;
    logic      dma_oamw;
    logic      joy_write;
    logic      joy_latch_bit;
    logic      joy_shift;
    logic      joy_bit;

    raster_timing i_raster (
        .clock25, .reset_n,
        .hs_o, .vs_o, .px_o, .py_o,
        .dot_tick_o(dot_tick), .vblank_set_o(vblank_set), .vblank_clear_o(vblank_clear)
    );

    // ------------------------------------------------------------------
    // Slot arbitration between the register file and DMA
    // ------------------------------------------------------------------
    prg_bus_arbiter i_arbiter (
        .clock25, .reset_n,
        .dot_tick_i(dot_tick), .dma_active_i(dma_active),
        .cpu_prga_i(reg_prga), .cpu_prgd_i(reg_prgd), .cpu_prgw_i(reg_prgw),
        .cpu_oama_i(reg_oama), .cpu_oamd_i(reg_oamd), .cpu_oamw_i(reg_oamw),
        .dma_prga_i(dma_prga), .dma_oamd_i(dma_oamd),
        .dma_oama_i(dma_oama), .dma_oamw_i(dma_oamw),
        .ce_cpu_o, .ce_ppu_o,
        .cpu_req_o(cpu_req), .cpu_resp_o(cpu_resp),
        .dma_read_o(dma_read), .dma_advance_o(dma_advance),
        .prga_o, .prgd_o, .prgw_o, .oama_o, .oamd_o, .oamw_o
    );

    ppu_registers i_registers (
        .clock25, .reset_n,
        .cpu_req_i(cpu_req), .cpu_resp_i(cpu_resp),
        .cpu_a_i, .cpu_o_i, .cpu_w_i, .cpu_r_i,
        .vblank_set_i(vblank_set), .vblank_clear_i(vblank_clear),
        .prgi_i, .oami_i, .joy_bit_i(joy_bit),
        .cpu_i_o, .nmi_o,
        .prga_o(reg_prga), .prgd_o(reg_prgd), .prgw_o(reg_prgw),
        .oama_o(reg_oama), .oamd_o(reg_oamd), .oamw_o(reg_oamw),
        .dma_start_o(dma_start), .dma_page_o(dma_page),
        .joy_write_o(joy_write), .joy_latch_bit_o(joy_latch_bit), .joy_shift_o(joy_shift)
    );

    oam_dma i_dma (
        .clock25, .reset_n,
        .dma_start_i(dma_start), .dma_page_i(dma_page),
        .dma_read_i(dma_read), .dma_advance_i(dma_advance), .prgi_i,
        .dma_active_o(dma_active), .prga_o(dma_prga),
        .oama_o(dma_oama), .oamd_o(dma_oamd), .oamw_o(dma_oamw)
    );

    joypad_port i_joypad (
        .clock25, .reset_n,
        .joy_write_i(joy_write), .joy_latch_bit_i(joy_latch_bit), .joy_shift_i(joy_shift),
        .joy1_i, .joy2_i,
        .joy_bit_o(joy_bit)
    );

endmodule

`default_nettype wire

//--- bench/ppu_core_tb.sv
// Testbench for the PPU bus and timing core
// Runs a table of CPU accesses and checks them against program memory and OAM models
`default_nettype none

module ppu_core_tb
    import ppu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int    CLK_PERIOD   = 40;
    localparam int    DRIVE_DELAY  = 2;
    localparam int    FRAME_CLOCKS = H_TOTAL * V_TOTAL;
    // Average dot period in clocks rounded up
    localparam int    DOT_CLOCKS   = (2 * H_TOTAL + DOTS_PER_LINE - 1) / DOTS_PER_LINE;
    localparam int    ENTRY_CLOCKS = 4 * 3 * DOT_CLOCKS;
    // The $4014 write slot plus 256 copy slots
    localparam int    DMA_TICKS    = 3 * (1 + 256);
    localparam byte_t DMA_PAGE     = 8'h05;

    typedef enum logic [2:0] {
        OP_ACCESS,
        OP_WAIT_NMI,
        OP_CHECK_NMI,
        OP_CHECK_PRG,
        OP_CHECK_OAM,
        OP_CHECK_DMA,
        OP_CHECK_SYNC
    } op_t;

    typedef struct packed {
        op_t         op;
        cpu_addr_t   addr;
        logic        write;
        byte_t       data;
        logic        check;
        byte_t       mask;
        logic [15:0] expected;
    } entry_t;

    logic      clock25;
    logic      reset_n;
    cpu_addr_t cpu_a;
    byte_t     cpu_o;
    logic      cpu_w;
    logic      cpu_r;
    byte_t     joy1;
    byte_t     joy2;
    byte_t     prgi;
    byte_t     oami;
    logic      hs;
    logic      vs;
    dot_pos_t  px;
    dot_pos_t  py;
    byte_t     cpu_i;
    cpu_addr_t prga;
    byte_t     prgd;
    logic      prgw;
    byte_t     oama;
    byte_t     oamd;
    logic      oamw;
    logic      ce_cpu;
    logic      ce_ppu;
    logic      nmi;

    byte_t     prg_mem [0:65535];
    byte_t     oam_mem [0:255];
    entry_t    table_q [$];
    logic      table_ready;

    ppu_core i_dut (
        .clock25(clock25), .reset_n(reset_n),
        .cpu_a_i(cpu_a), .cpu_o_i(cpu_o), .cpu_w_i(cpu_w), .cpu_r_i(cpu_r),
        .joy1_i(joy1), .joy2_i(joy2), .prgi_i(prgi), .oami_i(oami),
        .hs_o(hs), .vs_o(vs), .px_o(px), .py_o(py), .cpu_i_o(cpu_i),
        .prga_o(prga), .prgd_o(prgd), .prgw_o(prgw),
        .oama_o(oama), .oamd_o(oamd), .oamw_o(oamw),
        .ce_cpu_o(ce_cpu), .ce_ppu_o(ce_ppu), .nmi_o(nmi)
    );

    initial begin
        clock25 = 1'b0;
        forever #(CLK_PERIOD / 2) clock25 = ~clock25;
    end

    // ------------------------------------------------------------------
    // Memory models read combinationally and written at the falling edge
    // ------------------------------------------------------------------
    assign prgi = prg_mem[prga];
    assign oami = oam_mem[oama];

    always @(negedge clock25) begin
        if (prgw === 1'b1) begin
            prg_mem[prga] = prgd;
        end
        if (oamw === 1'b1) begin
            oam_mem[oama] = oamd;
        end
    end

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("[ERROR] time %0t ns, %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Returns just after the next ce_cpu pulse and counts dot ticks on the way
    task automatic wait_cpu_cycle(output int ticks);
        dot_pos_t last_px;
        ticks   = 0;
        last_px = '0;
        do begin
            @(posedge clock25);
            #(DRIVE_DELAY);
            if (ce_ppu === 1'b1) begin
                // The dot counter steps once per tick and wraps after 340
                if (ticks > 0) begin
                    check_value(int'(px), (int'(last_px) + 1) % DOTS_PER_LINE,
                                "dot counter step between ticks");
                end
                last_px = px;
                ticks++;
            end
        end while (ce_cpu !== 1'b1);
    endtask

    // Waits for the next low pulse of hs or vs and measures its length in clocks
    task automatic count_low_clocks(input logic use_vs, output int clocks);
        clocks = 0;
        do begin
            @(posedge clock25);
            #(DRIVE_DELAY);
        end while ((use_vs ? vs : hs) !== 1'b1);
        do begin
            @(posedge clock25);
            #(DRIVE_DELAY);
        end while ((use_vs ? vs : hs) !== 1'b0);
        do begin
            @(posedge clock25);
            #(DRIVE_DELAY);
            clocks++;
        end while ((use_vs ? vs : hs) === 1'b0);
    endtask

    task automatic queue_write(input cpu_addr_t addr, input byte_t data);
        entry_t e;
        e = '0;
        e.op    = OP_ACCESS;
        e.addr  = addr;
        e.write = 1'b1;
        e.data  = data;
        table_q.push_back(e);
    endtask

    task automatic queue_read(input cpu_addr_t addr, input byte_t mask, input byte_t expected);
        entry_t e;
        e = '0;
        e.op       = OP_ACCESS;
        e.addr     = addr;
        e.check    = 1'b1;
        e.mask     = mask;
        e.expected = 16'(expected);
        table_q.push_back(e);
    endtask

    task automatic add_step(input op_t op, input cpu_addr_t addr, input byte_t data,
                            input logic [15:0] expected);
        entry_t e;
        e = '0;
        e.op       = op;
        e.addr     = addr;
        e.data     = data;
        e.expected = expected;
        table_q.push_back(e);
    endtask

    // ------------------------------------------------------------------
    // Transaction table with expected bytes taken from the filled models
    // ------------------------------------------------------------------
    task automatic build_table();
        byte_t ctrl_val;
        byte_t prg_val;
        byte_t oam_val [0:3];
        logic  joy_bit;
        int    i;

        // Control registers after reset and their read-back
        queue_read(16'h2000, 8'hFF, 8'h10);
        queue_read(16'h2001, 8'hFF, 8'h0E);
        ctrl_val = 8'($urandom);
        queue_write(16'h2001, ctrl_val);
        queue_read(16'h2001, 8'hFF, ctrl_val);
        ctrl_val = 8'($urandom) & 8'h7F;
        queue_write(16'h2000, ctrl_val);
        queue_read(16'h2000, 8'hFF, ctrl_val);

        // Program memory pass-through
        prg_val = ~prg_mem[16'h0300];
        queue_write(16'h0300, prg_val);
        add_step(OP_CHECK_PRG, 16'h0300, 8'h00, 16'(prg_val));
        queue_read(16'h0300, 8'hFF, prg_val);
        queue_read(16'hC123, 8'hFF, prg_mem[16'hC123]);

        // OAM writes at consecutive addresses and their read-back
        queue_write(16'h2003, 8'h40);
        for (i = 0; i < 3; i++) begin
            oam_val[i] = ~oam_mem[8'h40 + i];
            queue_write(16'h2004, oam_val[i]);
        end
        oam_val[3] = oam_mem[8'h43];
        for (i = 0; i < 3; i++) begin
            add_step(OP_CHECK_OAM, cpu_addr_t'(16'h0040 + i), 8'h00, 16'(oam_val[i]));
        end
        queue_write(16'h2003, 8'h40);
        for (i = 0; i < 4; i++) begin
            queue_read(16'h2004, 8'hFF, oam_val[i]);
        end

        // Vertical blank, NMI, sync pulses and status read
        queue_write(16'h2000, 8'h80);
        add_step(OP_WAIT_NMI, 16'h0000, 8'h01, 16'(VBLANK_SET_LINE));
        add_step(OP_CHECK_SYNC, 16'h0000, 8'h00, 16'h0000);
        queue_read(16'h2002, 8'hE0, 8'h80);
        queue_read(16'h2002, 8'hE0, 8'h00);
        add_step(OP_CHECK_NMI, 16'h0000, 8'h00, 16'h0001);
        add_step(OP_WAIT_NMI, 16'h0000, 8'h00, 16'(VBLANK_CLEAR_LINE));

        // Sprite DMA restarts the OAM address at 0
        queue_write(16'h2003, 8'h10);
        queue_write(REG_DMA, DMA_PAGE);
        add_step(OP_CHECK_DMA, 16'h0000, DMA_PAGE, 16'h0000);
        queue_read(16'h2004, 8'hFF, prg_mem[{DMA_PAGE, 8'h00}]);

        // Joypad latch and 24 serial reads
        queue_write(REG_JOY, 8'h01);
        queue_write(REG_JOY, 8'h00);
        for (i = 0; i < 24; i++) begin
            joy_bit = (i < 8) ? joy1[i] : (i == 19);
            queue_read(REG_JOY, 8'hFF, 8'h40 | {7'b0, joy_bit});
        end
    endtask

    task automatic run_entry(input int idx, input entry_t e);
        int    ticks;
        int    want_ticks;
        int    low_clocks;
        int    k;
        string tag;

        tag = $sformatf("entry %0d at 0x%h", idx, e.addr);
        case (e.op)
            OP_ACCESS: begin
                wait_cpu_cycle(ticks);
                cpu_a = e.addr;
                cpu_o = e.data;
                cpu_w = e.write;
                cpu_r = !e.write;
                wait_cpu_cycle(ticks);
                cpu_w = 1'b0;
                cpu_r = 1'b0;
                // No ce_cpu may appear while the page copy runs
                want_ticks = (e.write && e.addr == REG_DMA) ? DMA_TICKS : 3;
                check_value(ticks, want_ticks, {tag, ", dot ticks until next ce_cpu"});
                if (e.check) begin
                    check_value(int'(cpu_i & e.mask), int'(e.expected & e.mask),
                                {tag, ", read data"});
                end
            end
            OP_WAIT_NMI: begin
                do begin
                    @(posedge clock25);
                    #(DRIVE_DELAY);
                end while (nmi !== e.data[0]);
                check_value(int'(py), int'(e.expected), {tag, ", dot line of nmi edge"});
            end
            OP_CHECK_NMI: check_value(int'(nmi), int'(e.expected), {tag, ", nmi level"});
            OP_CHECK_PRG: begin
                check_value(int'(prg_mem[e.addr]), int'(e.expected), {tag, ", program memory"});
            end
            OP_CHECK_OAM: begin
                check_value(int'(oam_mem[e.addr[7:0]]), int'(e.expected), {tag, ", OAM byte"});
            end
            OP_CHECK_DMA: begin
                for (k = 0; k < 256; k++) begin
                    check_value(int'(oam_mem[k]), int'(prg_mem[{e.data, 8'(k)}]),
                                $sformatf("%s, OAM byte %0d after DMA", tag, k));
                end
            end
            OP_CHECK_SYNC: begin
                // hs is low from column 752 to the line end, vs from line 523
                count_low_clocks(1'b0, low_clocks);
                check_value(low_clocks, H_TOTAL - 752, {tag, ", hs low clocks"});
                count_low_clocks(1'b1, low_clocks);
                check_value(low_clocks, (V_TOTAL - 523) * H_TOTAL, {tag, ", vs low clocks"});
            end
            default: ;
        endcase
    endtask

    initial begin : main
        int i;

        table_ready = 1'b0;
        reset_n     = 1'b0;
        cpu_a       = '0;
        cpu_o       = '0;
        cpu_w       = 1'b0;
        cpu_r       = 1'b0;
        void'($urandom(46));
        for (i = 0; i < 65536; i++) begin
            prg_mem[i] = 8'($urandom);
        end
        for (i = 0; i < 256; i++) begin
            oam_mem[i] = 8'($urandom);
        end
        joy1 = 8'($urandom);
        joy2 = 8'($urandom);
        build_table();
        table_ready = 1'b1;

        repeat (8) @(posedge clock25);
        #(DRIVE_DELAY);
        reset_n = 1'b1;

        for (i = 0; i < table_q.size(); i++) begin
            run_entry(i, table_q[i]);
        end
        $display("%0d table entries applied", table_q.size());
        $display("Verification passed");
        $finish;
    end

    // Three frames of slack plus a few CPU cycles per entry
    initial begin : watchdog
        longint limit_ns;

        wait (table_ready === 1'b1);
        limit_ns = longint'(3 * FRAME_CLOCKS + table_q.size() * ENTRY_CLOCKS) * CLK_PERIOD;
        #(limit_ns);
        $display("The run timed out after %0d ns before the table was finished", limit_ns);
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- compile.f
src/ppu_pkg.sv
src/raster_timing.sv
src/prg_bus_arbiter.sv
src/ppu_registers.sv
src/oam_dma.sv
src/joypad_port.sv
src/ppu_core.sv
bench/ppu_core_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary -Wno-fatal
TOP      = ppu_core_tb
FILELIST = compile.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
